// ==== src/adapterPkg.sv ====
package adapterPkg;

    localparam int WORD_WIDTH  = 64;  // one operand word from the host
    localparam int COUNT_WIDTH = 16;
    localparam int SUM_WIDTH   = 48;
    localparam int TERM_WIDTH  = 7;   // holds 0..64

    // operand word, the final three variable swaps in the host encoding
    typedef logic [WORD_WIDTH-1:0] botWord;

    // item count since the last start, wraps modulo 2^16
    typedef logic [COUNT_WIDTH-1:0] coeffCount;

    // running sum of terms, wraps modulo 2^48
    typedef logic [SUM_WIDTH-1:0] summedData;

    // per-item term, bits set in both words
    typedef logic [TERM_WIDTH-1:0] popTerm;

    // input FIFO payload, 129 bits
    typedef struct packed {
        botWord botLower;
        botWord botUpper;
        logic   startNewTop;  // restart count and sum with this item
    } inputItem;

    // output port and output FIFO payload, 64 bits
    typedef struct packed {
        coeffCount pcoeffCount;    // upper 16 bits
        summedData summedDataOut;  // lower 48 bits
    } resultItem;

    // FIFO depth, power of two
    localparam int DEFAULT_FIFO_DEPTH = 32;

    // synchronizer flops on each clock crossing
    localparam int DEFAULT_SYNC_STAGES = 4;

    // free entries kept to absorb items still in flight when ready drops
    localparam int DEFAULT_READY_SLACK = 5;

endpackage

// ==== src/hyperpipe.sv ====
`timescale 1ns/1ps

module hyperpipe #(
    parameter int CYCLES = 1,
    parameter int WIDTH  = 1
) (
    input  logic             clock,
    input  logic [WIDTH-1:0] dataIn,
    output logic [WIDTH-1:0] dataOut
);

    logic [WIDTH-1:0] stages [CYCLES];  // plain retiming registers

    always_ff @(posedge clock) begin
        stages[0] <= dataIn;
        for (int i = 1; i < CYCLES; i++) begin
            stages[i] <= stages[i-1];
        end
    end

    assign dataOut = stages[CYCLES-1];

endmodule

// ==== src/resetBridge.sv ====
`timescale 1ns/1ps

module resetBridge #(
    parameter int SYNC_STAGES = adapterPkg::DEFAULT_SYNC_STAGES
) (
    input  logic clock,
    input  logic clock2x,
    input  logic reset,
    output logic rst,
    output logic isInitialized,
    output logic rst2x
);

    localparam int INIT_CYCLES   = 8;  // base cycles from release to initialized
    localparam int RETIME_CYCLES = 5;  // extra fast-domain hold after sync

    logic [$clog2(INIT_CYCLES):0] initCount;
    logic [SYNC_STAGES-1:0]       rstSync;

    // registered copy of the host reset
    always_ff @(posedge clock) begin
        rst <= reset;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            initCount <= '0;
        end else if (!isInitialized) begin
            initCount <= initCount + 1'b1;  // stops once initialized
        end
    end

    assign isInitialized = (initCount == INIT_CYCLES);

    // carry rst into the fast domain
    always_ff @(posedge clock2x) begin
        rstSync <= {rstSync[SYNC_STAGES-2:0], rst};
    end

    // fast domain leaves reset after the slow domain
    hyperpipe #(
        .CYCLES(RETIME_CYCLES),
        .WIDTH (1)
    ) rst2xPipe (
        .clock  (clock2x),
        .dataIn (rstSync[SYNC_STAGES-1]),
        .dataOut(rst2x)
    );

endmodule

// ==== src/dualClockFifo.sv ====
`timescale 1ns/1ps

module dualClockFifo #(
    parameter int WIDTH       = 64,
    parameter int DEPTH       = adapterPkg::DEFAULT_FIFO_DEPTH,
    parameter int SYNC_STAGES = adapterPkg::DEFAULT_SYNC_STAGES
) (
    input  logic                    wrclk,
    input  logic                    writeEnable,
    input  logic [WIDTH-1:0]        dataIn,
    output logic [$clog2(DEPTH):0]  wrusedw,

    input  logic                    rdclk,
    input  logic                    rdclr,
    input  logic                    readEnable,
    output logic                    dataOutValid,
    output logic [WIDTH-1:0]        dataOut
);

    localparam int ADDR_W = $clog2(DEPTH);
    localparam int PTR_W  = ADDR_W + 1;  // extra wrap bit tells full from empty

    typedef logic [PTR_W-1:0] fifoPtr;

    function automatic fifoPtr grayToBin(input fifoPtr gray);
        fifoPtr bin;
        bin[PTR_W-1] = gray[PTR_W-1];
        for (int i = PTR_W - 2; i >= 0; i--) begin
            bin[i] = bin[i+1] ^ gray[i];
        end
        return bin;
    endfunction

    logic [WIDTH-1:0] mem [DEPTH];

    // write domain
    logic [SYNC_STAGES-1:0] clrSync;
    logic                   wrClr;
    fifoPtr                 wrBin;
    fifoPtr                 wrBinNext;
    fifoPtr                 wrGray;
    fifoPtr                 wrLevel;
    fifoPtr                 rdGraySync [SYNC_STAGES];
    fifoPtr                 rdBinSync;
    logic                   doWrite;

    // read domain
    fifoPtr                 rdBin;
    fifoPtr                 rdBinNext;
    fifoPtr                 rdGray;
    fifoPtr                 wrGraySync [SYNC_STAGES];
    logic                   notEmpty;

    // write side sees the read clear through its own synchronizer
    always_ff @(posedge wrclk) begin
        clrSync <= {clrSync[SYNC_STAGES-2:0], rdclr};
    end

    assign wrClr = clrSync[SYNC_STAGES-1];

    always_ff @(posedge wrclk) begin
        rdGraySync[0] <= rdGray;
        for (int i = 1; i < SYNC_STAGES; i++) begin
            rdGraySync[i] <= rdGraySync[i-1];
        end
    end

    assign rdBinSync = grayToBin(rdGraySync[SYNC_STAGES-1]);
    assign wrLevel   = wrBin - rdBinSync;
    assign doWrite   = writeEnable && !wrClr && (wrLevel != fifoPtr'(DEPTH));  // drop when full
    assign wrBinNext = wrBin + fifoPtr'(doWrite);

    always_ff @(posedge wrclk) begin
        if (wrClr) begin
            wrBin   <= '0;
            wrGray  <= '0;
            wrusedw <= fifoPtr'(DEPTH);  // report full while clearing
        end else begin
            wrBin   <= wrBinNext;
            wrGray  <= wrBinNext ^ (wrBinNext >> 1);
            wrusedw <= wrBinNext - rdBinSync;  // pessimistic, read side may have moved on
        end
    end

    always_ff @(posedge wrclk) begin
        if (doWrite) begin
            mem[wrBin[ADDR_W-1:0]] <= dataIn;
        end
    end

    // write pointer into the read domain
    always_ff @(posedge rdclk) begin
        wrGraySync[0] <= wrGray;
        for (int i = 1; i < SYNC_STAGES; i++) begin
            wrGraySync[i] <= wrGraySync[i-1];
        end
    end

    assign notEmpty  = (rdGray != wrGraySync[SYNC_STAGES-1]);
    assign rdBinNext = rdBin + 1'b1;

    // output register refills when it is taken or empty
    always_ff @(posedge rdclk) begin
        if (rdclr) begin
            rdBin        <= '0;
            rdGray       <= '0;
            dataOutValid <= 1'b0;
        end else if (readEnable) begin
            if (notEmpty) begin
                rdBin        <= rdBinNext;
                rdGray       <= rdBinNext ^ (rdBinNext >> 1);
                dataOutValid <= 1'b1;
            end else begin
                dataOutValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge rdclk) begin
        if (readEnable && notEmpty) begin
            dataOut <= mem[rdBin[ADDR_W-1:0]];
        end
    end

endmodule

// ==== src/coeffPipeline.sv ====
`timescale 1ns/1ps

module coeffPipeline (
    input  logic                  clock,  // the 2x clock
    input  logic                  rst,
    input  logic                  ivalid,
    output logic                  oready,
    input  adapterPkg::inputItem  item,
    output logic                  ovalid,
    input  logic                  iready,
    output adapterPkg::resultItem result
);

    function automatic adapterPkg::popTerm countOnes(input adapterPkg::botWord word);
        adapterPkg::popTerm total;
        total = '0;
        for (int i = 0; i < $bits(word); i++) begin
            total = total + adapterPkg::popTerm'(word[i]);
        end
        return total;
    endfunction

    logic                  advance;

    // stage 1, AND of the two words
    logic                  s1Valid;
    logic                  s1Start;
    adapterPkg::botWord    s1And;

    // stage 2, term
    logic                  s2Valid;
    logic                  s2Start;
    adapterPkg::popTerm    s2Term;

    // stage 3, accumulators
    logic                  s3Valid;
    adapterPkg::coeffCount countReg;
    adapterPkg::summedData sumReg;

    // whole pipe moves together, so nothing stalls mid-pipe
    assign advance = !s3Valid || iready;
    assign oready  = advance;

    always_ff @(posedge clock) begin
        if (rst) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
            s3Valid <= 1'b0;
        end else if (advance) begin
            s1Valid <= ivalid;
            s2Valid <= s1Valid;
            s3Valid <= s2Valid;
        end
    end

    always_ff @(posedge clock) begin
        if (advance) begin
            s1And   <= item.botLower & item.botUpper;
            s1Start <= item.startNewTop;
            s2Term  <= countOnes(s1And);
            s2Start <= s1Start;
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            countReg <= '0;
            sumReg   <= '0;
        end else if (advance && s2Valid) begin
            if (s2Start) begin
                countReg <= adapterPkg::coeffCount'(1);  // start item counts itself
                sumReg   <= adapterPkg::summedData'(s2Term);
            end else begin
                countReg <= countReg + 1'b1;  // wraps modulo 2^16
                sumReg   <= sumReg + adapterPkg::summedData'(s2Term);
            end
        end
    end

    assign ovalid = s3Valid;
    assign result = '{pcoeffCount: countReg, summedDataOut: sumReg};

endmodule

// ==== src/clock2xAdapter.sv ====
`timescale 1ns/1ps

module clock2xAdapter #(
    parameter int FIFO_DEPTH  = adapterPkg::DEFAULT_FIFO_DEPTH,
    parameter int SYNC_STAGES = adapterPkg::DEFAULT_SYNC_STAGES,
    parameter int READY_SLACK = adapterPkg::DEFAULT_READY_SLACK
) (
    input  logic                  clock,
    input  logic                  clock2x,
    input  logic                  reset,
    input  logic                  ivalid,
    output logic                  oready,

    input  logic                  startNewTop,
    input  adapterPkg::botWord    botLower,
    input  adapterPkg::botWord    botUpper,

    output logic                  ovalid,
    input  logic                  iready,
    output adapterPkg::resultItem summedDataPcoeffCountOut  // count in the upper 16 bits
);

    localparam int USEDW_W         = $clog2(FIFO_DEPTH) + 1;
    localparam int READY_PIPE_DEPTH = 2;

    // highest fill level that still takes new data
    localparam logic [USEDW_W-1:0] READY_LEVEL = USEDW_W'(FIFO_DEPTH - READY_SLACK);

    logic                  rst;
    logic                  isInitialized;
    logic                  rst2x;

    adapterPkg::inputItem  hostItem;
    adapterPkg::inputItem  item2x;
    adapterPkg::resultItem result2x;

    logic                  ivalid2x;
    logic                  oready2x;
    logic                  ovalid2x;
    logic                  iready2x;

    logic [USEDW_W-1:0]    inputUsedw;
    logic [USEDW_W-1:0]    outputUsedw2x;
    logic                  receivingData;
    logic                  outputHasRoom2x;
    logic                  movingDataToOutput2x;

    resetBridge #(
        .SYNC_STAGES(SYNC_STAGES)
    ) bridge (
        .clock        (clock),
        .clock2x      (clock2x),
        .reset        (reset),
        .rst          (rst),
        .isInitialized(isInitialized),
        .rst2x        (rst2x)
    );

    assign hostItem      = '{botLower: botLower, botUpper: botUpper, startNewTop: startNewTop};
    assign oready        = (inputUsedw <= READY_LEVEL) && isInitialized;
    assign receivingData = ivalid && oready;

    dualClockFifo #(
        .WIDTH      ($bits(adapterPkg::inputItem)),
        .DEPTH      (FIFO_DEPTH),
        .SYNC_STAGES(SYNC_STAGES)
    ) inputFifo (
        .wrclk       (clock),
        .writeEnable (receivingData),
        .dataIn      (hostItem),
        .wrusedw     (inputUsedw),
        .rdclk       (clock2x),
        .rdclr       (rst2x),
        .readEnable  (oready2x),  // pipeline accept doubles as pop
        .dataOutValid(ivalid2x),
        .dataOut     (item2x)
    );

    coeffPipeline fastPipeline (
        .clock (clock2x),
        .rst   (rst2x),
        .ivalid(ivalid2x),
        .oready(oready2x),
        .item  (item2x),
        .ovalid(ovalid2x),
        .iready(iready2x),
        .result(result2x)
    );

    assign outputHasRoom2x = (outputUsedw2x <= READY_LEVEL);

    // retimed, the slack absorbs the extra cycles
    hyperpipe #(
        .CYCLES(READY_PIPE_DEPTH),
        .WIDTH (1)
    ) readyPipe (
        .clock  (clock2x),
        .dataIn (outputHasRoom2x),
        .dataOut(iready2x)
    );

    assign movingDataToOutput2x = ovalid2x && iready2x;

    dualClockFifo #(
        .WIDTH      ($bits(adapterPkg::resultItem)),
        .DEPTH      (FIFO_DEPTH),
        .SYNC_STAGES(SYNC_STAGES)
    ) outputFifo (
        .wrclk       (clock2x),
        .writeEnable (movingDataToOutput2x),
        .dataIn      (result2x),
        .wrusedw     (outputUsedw2x),
        .rdclk       (clock),
        .rdclr       (rst),
        .readEnable  (iready || !ovalid),  // refill when empty, lookahead style
        .dataOutValid(ovalid),
        .dataOut     (summedDataPcoeffCountOut)
    );

endmodule

// ==== verification/clock2xAdapter_asserts.sv ====
`timescale 1ns/1ps

module clock2xAdapter_asserts #(
    parameter int FIFO_DEPTH = adapterPkg::DEFAULT_FIFO_DEPTH
) (
    input logic                        clock,
    input logic                        rst,
    input logic                        oready,
    input logic                        ovalid,
    input logic                        iready,
    input adapterPkg::resultItem       summedDataPcoeffCountOut,
    input logic                        receivingData,
    input logic [$clog2(FIFO_DEPTH):0] inputLevel  // true write-side level, not the registered one
);

    // a stalled result stays put until the host takes it
    outputHeld: assert property (@(posedge clock) disable iff (rst)
        (ovalid && !iready) |=> (ovalid && $stable(summedDataPcoeffCountOut)))
        else $error("result changed while the host held iready low");

    quietInReset: assert property (@(posedge clock)
        (rst && $past(rst)) |-> (!oready && !ovalid))
        else $error("handshake output high during reset");

    noWriteWhenFull: assert property (@(posedge clock) disable iff (rst)
        receivingData |-> (int'(inputLevel) < FIFO_DEPTH))
        else $error("input FIFO written at full level");

endmodule

bind clock2xAdapter clock2xAdapter_asserts #(
    .FIFO_DEPTH(FIFO_DEPTH)
) asserts (
    .clock                   (clock),
    .rst                     (rst),
    .oready                  (oready),
    .ovalid                  (ovalid),
    .iready                  (iready),
    .summedDataPcoeffCountOut(summedDataPcoeffCountOut),
    .receivingData           (receivingData),
    .inputLevel              (inputFifo.wrLevel)
);

// ==== verification/clock2xAdapterTb.sv ====
`timescale 1ns/1ps

module clock2xAdapterTb;

    localparam int FIFO_DEPTH      = adapterPkg::DEFAULT_FIFO_DEPTH;
    localparam int STREAM_ITEMS    = 300;
    localparam int FILL_LOW_CYCLES = 100;  // oready low this long means both FIFOs are full
    localparam int QUIET_CYCLES    = 20;   // idle time in which an extra result would show
    localparam int TOTAL_ITEMS     = 1 + 2 * STREAM_ITEMS + 2 * FIFO_DEPTH;
    localparam int TIMEOUT_CYCLES  = TOTAL_ITEMS * 40;

    logic                  clock;
    logic                  clock2x;
    logic                  reset;
    logic                  ivalid;
    logic                  oready;
    logic                  startNewTop;
    adapterPkg::botWord    botLower;
    adapterPkg::botWord    botUpper;
    logic                  ovalid;
    logic                  iready;
    adapterPkg::resultItem summedDataPcoeffCountOut;

    logic [15:0]           lfsr;
    int                    cycleCount = 0;
    adapterPkg::coeffCount modelCount;
    adapterPkg::summedData modelSum;
    adapterPkg::resultItem expected [$];  // results still owed by the DUT, in order

    clock2xAdapter #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) clock2xAdapter_inst (
        .clock                   (clock),
        .clock2x                 (clock2x),
        .reset                   (reset),
        .ivalid                  (ivalid),
        .oready                  (oready),
        .startNewTop             (startNewTop),
        .botLower                (botLower),
        .botUpper                (botUpper),
        .ovalid                  (ovalid),
        .iready                  (iready),
        .summedDataPcoeffCountOut(summedDataPcoeffCountOut)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial begin
        clock2x = 1'b0;
        forever #5 clock2x = ~clock2x;
    end

    task automatic stopOnError();
        $display("Simulation failed");
        $fatal(1, "stopping at the first error");
    endtask

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TIMEOUT_CYCLES) begin
            $display("ERROR: no finish within %0d clock cycles, the DUT seems hung", TIMEOUT_CYCLES);
            stopOnError();
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic nextBit();
        logic feedback;
        feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], feedback};
        return feedback;
    endfunction

    function automatic logic [63:0] randomBits(input int count);
        logic [63:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[62:0], nextBit()};
        end
        return bits;
    endfunction

    task automatic checkFlag(input logic actual, input logic want, input string what);
        if (actual !== want) begin
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, actual, want);
            stopOnError();
        end
    endtask

    task automatic checkCount(input adapterPkg::coeffCount actual, input adapterPkg::coeffCount want);
        if (actual !== want) begin
            $display("CHECK FAILED at %0t: result count %0d, expected %0d", $time, actual, want);
            stopOnError();
        end
    endtask

    task automatic checkSum(input adapterPkg::summedData actual, input adapterPkg::summedData want);
        if (actual !== want) begin
            $display("CHECK FAILED at %0t: result sum %0d, expected %0d", $time, actual, want);
            stopOnError();
        end
    endtask

    // term is the number of bit positions set in both words
    task automatic acceptInput();
        adapterPkg::resultItem next;
        int                    term;
        term = $countones(botLower & botUpper);
        if (startNewTop) begin
            modelCount = adapterPkg::coeffCount'(1);
            modelSum   = adapterPkg::summedData'(term);
        end else begin
            modelCount = modelCount + adapterPkg::coeffCount'(1);
            modelSum   = modelSum + adapterPkg::summedData'(term);
        end
        next.pcoeffCount   = modelCount;
        next.summedDataOut = modelSum;
        expected.push_back(next);
    endtask

    task automatic takeOutput();
        adapterPkg::resultItem want;
        if (expected.size() == 0) begin
            $display("ERROR at %0t: a result came out with no accepted item left", $time);
            stopOnError();
        end else begin
            want = expected.pop_front();
            checkCount(summedDataPcoeffCountOut.pcoeffCount, want.pcoeffCount);
            checkSum(summedDataPcoeffCountOut.summedDataOut, want.summedDataOut);
        end
    endtask

    // outputs are stable at the falling edge and have no path from the inputs
    task automatic stepCycle(input logic offerItem, input logic takeResult,
                             input logic forceStart, output logic accepted);
        @(negedge clock);
        ivalid = offerItem;
        iready = takeResult;
        if (offerItem) begin
            botLower    = randomBits(64);
            botUpper    = randomBits(64);
            startNewTop = forceStart || (randomBits(3) == 64'd0);  // about one in eight
        end
        accepted = ivalid && oready;
        if (accepted) begin
            acceptInput();
        end
        if (ovalid && iready) begin
            takeOutput();
        end
    endtask

    task automatic drainResults();
        logic accepted;
        while (expected.size() > 0) begin
            stepCycle(1'b0, 1'b1, 1'b0, accepted);
        end
        repeat (QUIET_CYCLES) begin
            stepCycle(1'b0, 1'b1, 1'b0, accepted);
        end
    endtask

    task automatic runStream(input int items, input logic randomReady);
        logic accepted;
        logic offer;
        logic take;
        int   taken;
        taken = 0;
        while (taken < items) begin
            offer = nextBit();
            take  = randomReady ? nextBit() : 1'b1;
            stepCycle(offer, take, 1'b0, accepted);
            if (accepted) begin
                taken++;
            end
        end
        drainResults();
    endtask

    task automatic fillAndRelease();
        logic accepted;
        int   lowCycles;
        lowCycles = 0;
        while (lowCycles < FILL_LOW_CYCLES) begin
            stepCycle(1'b1, 1'b0, 1'b0, accepted);
            lowCycles = accepted ? 0 : lowCycles + 1;
        end
        drainResults();  // iready released here
    endtask

    initial begin
        logic accepted;
        reset       = 1'b1;
        ivalid      = 1'b0;
        iready      = 1'b0;
        startNewTop = 1'b0;
        botLower    = '0;
        botUpper    = '0;
        lfsr        = 16'd22911;
        modelCount  = '0;
        modelSum    = '0;
        repeat (2) @(negedge clock);
        checkFlag(oready, 1'b0, "oready during reset");
        checkFlag(ovalid, 1'b0, "ovalid during reset");
        reset = 1'b0;
        while (oready !== 1'b1) begin
            stepCycle(1'b0, 1'b1, 1'b0, accepted);  // no input offered
        end
        accepted = 1'b0;
        while (!accepted) begin
            stepCycle(1'b1, 1'b1, 1'b1, accepted);  // single start item
        end
        drainResults();
        runStream(STREAM_ITEMS, 1'b0);
        runStream(STREAM_ITEMS, 1'b1);
        fillAndRelease();
        if (expected.size() != 0) begin
            $display("ERROR: %0d expected results never came out", expected.size());
            stopOnError();
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

// ==== all.f ====
src/adapterPkg.sv
src/hyperpipe.sv
src/resetBridge.sv
src/dualClockFifo.sv
src/coeffPipeline.sv
src/clock2xAdapter.sv
verification/clock2xAdapter_asserts.sv
verification/clock2xAdapterTb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := clock2xAdapterTb
FILELIST   := all.f
BUILD_DIR  := obj_dir
VFLAGS     := --binary --timing --assert -Wno-fatal --top-module $(TOP) --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing -Wall --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
